// ==== project.f ====
verilog/hog_pkg.sv
verilog/hog_cell_bank.sv
verilog/hog_cell_addr.sv
verilog/hog_bin_accum.sv
verilog/hog_bank_array.sv
verilog/hog_clear_seq.sv
verilog/hog_histogram_top.sv
dv/hog_checker.sv
dv/hog_sva.sv
dv/hog_tb.sv

// ==== Makefile ====
TOP := hog_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f project.f -o hog_sim
	./obj_dir/hog_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	  test $$status -eq 0 && ! grep -qF "*** TEST FAILED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/hog_tb.sv ====
// Testbench for the HOG cell-histogram accumulator. Applies a table of sample
// groups, sweeps the cells around each one through the readout port and
// replays the sweeps after a frame_start clear. hog_checker does the compares.
`timescale 1ns/1ps
`default_nettype none

module hog_tb import hog_pkg::*; ();

  localparam int NUM_TESTS      = 8;
  localparam int NUM_RAND_READS = 32;

  logic        aclk;
  logic        rst_n;
  logic        in_valid;
  hog_sample_t in_sample;
  logic        in_ready;
  logic        rd_valid;
  rd_req_t     rd_req;
  logic        rd_ready;
  hist_t       rd_data;
  logic        rd_data_valid;
  logic        frame_start;
  logic        frame_done;
  int          tb_errs = 0;

  // ------------------------------------------------------------
  // test table, intensity order {horizontal, diagonal, vertical, own}
  // ------------------------------------------------------------
  string t_name [NUM_TESTS] = '{"interior", "corner_origin", "corner_last", "edge_top",
                                "edge_left", "bypass_b2b", "gapped_repeat", "wide_sum"};
  mod_coord_t  t_row   [NUM_TESTS] = '{8'd50, 8'd0, 8'd135, 8'd0, 8'd70, 8'd100, 8'd90, 8'd20};
  mod_coord_t  t_col   [NUM_TESTS] = '{8'd50, 8'd0, 8'd135, 8'd70, 8'd0, 8'd20, 8'd110, 8'd120};
  bin_t        t_bin   [NUM_TESTS] = '{5'd3, 5'd0, 5'd17, 5'd8, 5'd11, 5'd5, 5'd14, 5'd9};
  int          t_reps  [NUM_TESTS] = '{1, 1, 1, 1, 1, 6, 3, 4};
  bit          t_b2b   [NUM_TESTS] = '{0, 0, 0, 0, 0, 1, 0, 1};
  int          t_cells [NUM_TESTS] = '{4, 1, 1, 2, 2, 4, 4, 4};  // in-range targets
  hist_t [3:0] t_inten [NUM_TESTS] = '{
    {35'd40, 35'd30, 35'd20, 35'd10},
    {35'd7, 35'd6, 35'd5, 35'd9},
    {35'd13, 35'd12, 35'd11, 35'd15},
    {35'd24, 35'd23, 35'd22, 35'd21},
    {35'd34, 35'd33, 35'd32, 35'd31},
    {35'd4, 35'd3, 35'd2, 35'd1},
    {35'd1000, 35'd100, 35'd10, 35'd1},
    {35'h1_0000_0003, 35'h0_8000_0002, 35'h0_FFFF_FFFF, 35'h1_0000_0001}
  };

  hog_histogram_top hog_histogram_top_inst (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_sample     (in_sample),
    .in_ready      (in_ready),
    .rd_valid      (rd_valid),
    .rd_req        (rd_req),
    .rd_ready      (rd_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .frame_start   (frame_start),
    .frame_done    (frame_done)
  );

  hog_checker hog_checker_inst (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_sample     (in_sample),
    .rd_valid      (rd_valid),
    .rd_ready      (rd_ready),
    .rd_req        (rd_req),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .frame_start   (frame_start),
    .frame_done    (frame_done)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;  // 100 ns period
  end

  task automatic idle(input int n);
    repeat (n) @(posedge aclk);
  endtask

  task automatic wait_clear_done(input string what);
    int cycles;
    cycles = 0;
    @(posedge aclk);
    while (!in_ready && cycles <= int'(CLEAR_WORDS) + 10) begin
      cycles++;
      @(posedge aclk);
    end
    if (!in_ready) begin
      $display("in_ready did not return high after the %s", what);
      tb_errs++;
    end
  endtask

  task automatic issue_read(input int row, input int col, input int bin);
    @(posedge aclk);
    rd_valid <= 1'b1;
    rd_req   <= '{cell_row: cell_coord_t'(row), cell_col: cell_coord_t'(col), bin: bin_t'(bin)};
  endtask

  task automatic end_reads();
    @(posedge aclk);
    rd_valid <= 1'b0;
    idle(2);  // last word lands, counters settle
  endtask

  task automatic run_group(input int i);
    hog_sample_t s;
    s = '{mod_row: t_row[i], mod_col: t_col[i], bin: t_bin[i], intensity: t_inten[i]};
    for (int r = 0; r < t_reps[i]; r++) begin
      @(posedge aclk);
      if (!in_ready) begin
        $display("in_ready was low while sending the %s samples", t_name[i]);
        tb_errs++;
      end
      in_valid  <= 1'b1;
      in_sample <= s;
      if (!t_b2b[i] && r < t_reps[i] - 1) begin
        @(posedge aclk);
        in_valid <= 1'b0;  // one idle cycle between repeats
      end
    end
    @(posedge aclk);
    in_valid <= 1'b0;
  endtask

  // every bin of the 3x3 cells around the group's own cell
  task automatic sweep(input int i, input int exp_nz);
    int r0;
    int c0;
    r0 = int'(t_row[i]) / 4;
    c0 = int'(t_col[i]) / 4;
    hog_checker_inst.start_sweep();
    for (int r = r0 - 1; r <= r0 + 1; r++) begin
      for (int c = c0 - 1; c <= c0 + 1; c++) begin
        if (r >= 0 && r < int'(CELLS_PER_SIDE) && c >= 0 && c < int'(CELLS_PER_SIDE)) begin
          for (int b = 0; b < int'(NUM_BINS); b++) begin
            issue_read(r, c, b);
          end
        end
      end
    end
    end_reads();
    hog_checker_inst.end_sweep(exp_nz);
  endtask

  function automatic longint est_cycles();
    longint n;
    n = 2 * (longint'(CLEAR_WORDS) + 16) + NUM_RAND_READS + 16;
    for (int i = 0; i < NUM_TESTS; i++) begin
      n += 2 * t_reps[i] + 8 + 2 * (9 * NUM_BINS + 4);  // group, gap, sweep and replay
    end
    return n;
  endfunction

  initial begin : watchdog
    longint limit_ns;
    limit_ns = 2 * est_cycles() * 100;
    #(limit_ns);
    $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(18962));
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_sample   = '0;
    rd_valid    = 1'b0;
    rd_req      = '0;
    frame_start = 1'b0;
    repeat (5) @(posedge aclk);
    rst_n <= 1'b1;
    wait_clear_done("reset clear");

    hog_checker_inst.set_test("reset_readout");
    for (int n = 0; n < NUM_RAND_READS; n++) begin
      issue_read($urandom_range(33, 0), $urandom_range(33, 0), $urandom_range(17, 0));
    end
    end_reads();

    for (int i = 0; i < NUM_TESTS; i++) begin
      hog_checker_inst.set_test(t_name[i]);
      run_group(i);
      idle(3);  // nothing in flight before readout
      sweep(i, t_cells[i]);
    end

    // ------------------------------------------------------------
    // new frame, all previous hits must read back as zero
    // ------------------------------------------------------------
    hog_checker_inst.set_test("frame_start_clear");
    @(posedge aclk);
    frame_start <= 1'b1;
    @(posedge aclk);
    frame_start <= 1'b0;
    wait_clear_done("frame_start clear");
    for (int i = 0; i < NUM_TESTS; i++) begin
      hog_checker_inst.set_test({t_name[i], "_cleared"});
      sweep(i, 0);
    end
    idle(3);

    $display("error count: checker %0d, testbench %0d", hog_checker_inst.err_cnt, tb_errs);
    if (hog_checker_inst.err_cnt == 0 && tb_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/hog_sva.sv ====
// Protocol assertions for the HOG accumulator top level, attached by bind.
// Covers input gating during clear, the frame_done pulse and readout latency.
`timescale 1ns/1ps
`default_nettype none

module hog_sva (
  input logic aclk,
  input logic rst_n,
  input logic clear_en,
  input logic frame_start,
  input logic in_ready,
  input logic frame_done,
  input logic rd_valid,
  input logic rd_ready,
  input logic rd_data_valid
);

  a_ready_low_in_clear : assert property (@(posedge aclk) disable iff (!rst_n)
    frame_start |=> clear_en && !in_ready)
    else $error("frame_start did not start a clear with in_ready low");

  a_done_one_cycle : assert property (@(posedge aclk) disable iff (!rst_n)
    frame_done |=> !frame_done)
    else $error("frame_done stayed high for two cycles");

  a_rd_latency : assert property (@(posedge aclk) disable iff (!rst_n)
    (rd_valid && rd_ready) |=> rd_data_valid)
    else $error("rd_data_valid missing one cycle after a readout transfer");

  a_rd_no_spurious : assert property (@(posedge aclk) disable iff (!rst_n)
    !(rd_valid && rd_ready) |=> !rd_data_valid)
    else $error("rd_data_valid without a readout transfer");

endmodule

bind hog_histogram_top hog_sva hog_sva_inst (
  .aclk          (aclk),
  .rst_n         (rst_n),
  .clear_en      (clear_en),
  .frame_start   (frame_start),
  .in_ready      (in_ready),
  .frame_done    (frame_done),
  .rd_valid      (rd_valid),
  .rd_ready      (rd_ready),
  .rd_data_valid (rd_data_valid)
);

`default_nettype wire

// ==== dv/hog_checker.sv ====
// Scoreboard for the HOG accumulator. Builds a reference histogram from the
// accepted samples and checks each readout word, the frame_done cycle and the
// clear length. The testbench names the test and brackets each readout sweep.
`timescale 1ns/1ps
`default_nettype none

module hog_checker import hog_pkg::*; (
  input logic        aclk,
  input logic        rst_n,
  input logic        in_valid,
  input logic        in_ready,
  input hog_sample_t in_sample,
  input logic        rd_valid,
  input logic        rd_ready,
  input rd_req_t     rd_req,
  input hist_t       rd_data,
  input logic        rd_data_valid,
  input logic        frame_start,
  input logic        frame_done
);

  hist_t      model [CELLS_PER_SIDE][CELLS_PER_SIDE][NUM_BINS];
  rd_req_t    pend_req;      // request whose data comes back next cycle
  logic [2:0] done_exp;      // accept, write, pulse
  int         low_run  = 0;  // cycles with in_ready low
  int         nz_cnt   = 0;  // nonzero words seen in the current sweep
  int         err_cnt  = 0;
  string      test_name = "reset";

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic start_sweep();
    nz_cnt = 0;
  endtask

  task automatic end_sweep(input int exp_nz);
    if (nz_cnt != exp_nz) begin
      $display("[FAIL] %s: nonzero words expected %0d actual %0d", test_name, exp_nz, nz_cnt);
      err_cnt++;
    end
  endtask

  task automatic clear_model();
    foreach (model[r, c, b]) begin
      model[r][c][b] = '0;
    end
  endtask

  // ------------------------------------------------------------
  // reference update, own / vertical / diagonal / horizontal
  // ------------------------------------------------------------
  task automatic add_sample(input hog_sample_t s);
    int r0;
    int c0;
    int dr;
    int dc;
    int rr [4];
    int cc [4];
    r0 = int'(s.mod_row) / 4;
    c0 = int'(s.mod_col) / 4;
    dr = s.mod_row[1] ? 1 : -1;  // lower half of the cell looks down
    dc = s.mod_col[1] ? 1 : -1;
    rr = '{r0, r0 + dr, r0 + dr, r0};
    cc = '{c0, c0, c0 + dc, c0 + dc};
    for (int j = 0; j < 4; j++) begin
      if (rr[j] >= 0 && rr[j] < int'(CELLS_PER_SIDE) && cc[j] >= 0 &&
          cc[j] < int'(CELLS_PER_SIDE)) begin
        model[rr[j]][cc[j]][s.bin] += s.intensity[j];
      end
    end
  endtask

  always @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      clear_model();
      done_exp = '0;
      low_run  = 0;
    end else begin
      if (rd_data_valid) begin
        if (rd_data != '0) nz_cnt++;
        if (rd_data !== model[pend_req.cell_row][pend_req.cell_col][pend_req.bin]) begin
          $display("[FAIL] %s: cell (%0d,%0d) bin %0d expected %0d actual %0d", test_name,
                   pend_req.cell_row, pend_req.cell_col, pend_req.bin,
                   model[pend_req.cell_row][pend_req.cell_col][pend_req.bin], rd_data);
          err_cnt++;
        end
      end
      if (frame_done !== done_exp[2]) begin
        $display("[FAIL] %s: frame_done expected %0b actual %0b", test_name, done_exp[2],
                 frame_done);
        err_cnt++;
      end
      done_exp = {done_exp[1:0], in_valid && in_ready && in_sample.mod_row == LAST_MOD &&
                  in_sample.mod_col == LAST_MOD};
      if (!in_ready) begin
        low_run++;
      end else begin
        if (low_run != 0 && low_run != int'(CLEAR_WORDS)) begin
          $display("[FAIL] %s: clear cycles expected %0d actual %0d", test_name, CLEAR_WORDS,
                   low_run);
          err_cnt++;
        end
        low_run = 0;
      end
      if (rd_valid && !rd_ready) begin
        $display("%s: a readout request was refused while the input was idle", test_name);
        err_cnt++;
      end
      if (rd_valid && rd_ready) pend_req = rd_req;
      if (frame_start) begin
        clear_model();  // new frame, everything back to zero
      end else if (in_valid && in_ready) begin
        add_sample(in_sample);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hog_histogram_top.sv ====
// HOG cell-histogram accumulator top. Samples go through the cell-address
// stage and the add stage into four banks; readout shares port A when idle.
`timescale 1ns/1ps
`default_nettype none

module hog_histogram_top import hog_pkg::*; (
  input  logic        aclk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  hog_sample_t in_sample,
  output logic        in_ready,
  input  logic        rd_valid,
  input  rd_req_t     rd_req,
  output logic        rd_ready,
  output hist_t       rd_data,
  output logic        rd_data_valid,
  input  logic        frame_start,
  output logic        frame_done
);

  logic       sample_fire;
  logic       last_mod;
  logic       rd_go;
  logic       clear_en;
  bank_addr_t clear_addr;
  bank_lane_t rd_lane [NUM_BANKS];
  bank_lane_t lane_q  [NUM_BANKS];
  bank_lane_t wr_lane [NUM_BANKS];
  hist_t      rd_word [NUM_BANKS];

  // ------------------------------------------------------------
  // handshake gating
  // ------------------------------------------------------------
  assign sample_fire = in_valid & in_ready;
  assign last_mod    = (in_sample.mod_row == LAST_MOD) && (in_sample.mod_col == LAST_MOD);
  assign rd_ready    = in_ready & ~in_valid; // samples own port A first
  assign rd_go       = rd_valid & rd_ready;

  hog_clear_seq hog_clear_seq_inst (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .sample_fire (sample_fire),
    .last_mod    (last_mod),
    .clear_en    (clear_en),
    .clear_addr  (clear_addr),
    .in_ready    (in_ready),
    .frame_done  (frame_done)
  );

  hog_cell_addr hog_cell_addr_inst (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .sample_valid (sample_fire),
    .sample       (in_sample),
    .rd_lane      (rd_lane),
    .lane_q       (lane_q)
  );

  hog_bin_accum hog_bin_accum_inst (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .lane_q  (lane_q),
    .rd_word (rd_word),
    .wr_lane (wr_lane)
  );

  hog_bank_array hog_bank_array_inst (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .clear_en      (clear_en),
    .clear_addr    (clear_addr),
    .rd_lane       (rd_lane),
    .wr_lane       (wr_lane),
    .rd_go         (rd_go),
    .rd_req        (rd_req),
    .rd_word       (rd_word),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

endmodule

`default_nettype wire

// ==== verilog/hog_clear_seq.sv ====
// Clear sequencer. Zeroes all banks after reset and on each frame_start, two
// words per cycle, then opens the sample input. Also times frame_done.
`timescale 1ns/1ps
`default_nettype none

module hog_clear_seq import hog_pkg::*; (
  input  logic       aclk,
  input  logic       rst_n,
  input  logic       frame_start,
  input  logic       sample_fire,
  input  logic       last_mod,
  output logic       clear_en,
  output bank_addr_t clear_addr,
  output logic       in_ready,
  output logic       frame_done
);

  clear_state_t state;
  bank_addr_t   clr_addr_q; // even word, port B takes the odd one
  logic [2:0]   done_sr;    // accept, write, then pulse

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_CLEAR;
      clr_addr_q <= '0;
    end else if (frame_start) begin
      state      <= ST_CLEAR; // restart even mid-clear
      clr_addr_q <= '0;
    end else if (state == ST_CLEAR) begin
      if (clr_addr_q == bank_addr_t'(2 * (CLEAR_WORDS - 1))) begin
        state      <= ST_RUN;
        clr_addr_q <= '0;
      end else begin
        clr_addr_q <= clr_addr_q + bank_addr_t'(2);
      end
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      done_sr <= '0;
    end else begin
      done_sr <= {done_sr[1:0], sample_fire & last_mod};
    end
  end

  assign clear_en   = (state == ST_CLEAR);
  assign clear_addr = clr_addr_q;
  assign in_ready   = (state == ST_RUN);
  assign frame_done = done_sr[2]; // one cycle after the last word lands

endmodule

`default_nettype wire

// ==== verilog/hog_bank_array.sv ====
// The four histogram banks and their port muxes. Clear owns both ports,
// otherwise port A serves the accumulate read or the readout and port B the
// accumulate write. rd_data is picked from the bank latched with the request.
`timescale 1ns/1ps
`default_nettype none

module hog_bank_array import hog_pkg::*; (
  input  logic       aclk,
  input  logic       rst_n,
  input  logic       clear_en,
  input  bank_addr_t clear_addr,
  input  bank_lane_t rd_lane [NUM_BANKS],
  input  bank_lane_t wr_lane [NUM_BANKS],
  input  logic       rd_go,
  input  rd_req_t    rd_req,
  output hist_t      rd_word [NUM_BANKS],
  output hist_t      rd_data,
  output logic       rd_data_valid
);

  bank_sel_t            rd_bank;
  bank_addr_t           rd_addr;
  bank_sel_t            rd_bank_q;
  logic [NUM_BANKS-1:0] b_we;
  bank_addr_t           a_addr [NUM_BANKS];
  bank_addr_t           b_addr [NUM_BANKS];
  hist_t                b_din  [NUM_BANKS];

  assign rd_bank = hog_bank_of(rd_req.cell_row, rd_req.cell_col);
  assign rd_addr = hog_bank_addr(rd_req.cell_row, rd_req.cell_col, rd_req.bin);

  // ------------------------------------------------------------
  // per-bank port muxes
  // ------------------------------------------------------------
  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    // readout address goes to every idle bank, rd_bank_q picks the one that counts
    assign a_addr[k] = clear_en ? clear_addr : (rd_lane[k].en ? rd_lane[k].addr : rd_addr);
    assign b_we[k]   = clear_en | wr_lane[k].en;
    assign b_addr[k] = clear_en ? clear_addr + bank_addr_t'(1) : wr_lane[k].addr; // odd word
    assign b_din[k]  = clear_en ? '0 : wr_lane[k].inc;

    hog_cell_bank hog_cell_bank_inst (
      .aclk   (aclk),
      .a_we   (clear_en),
      .a_addr (a_addr[k]),
      .a_din  ('0),
      .a_dout (rd_word[k]),
      .b_we   (b_we[k]),
      .b_addr (b_addr[k]),
      .b_din  (b_din[k])
    );
  end

  // ------------------------------------------------------------
  // readout return path
  // ------------------------------------------------------------
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_go; // one-cycle read latency
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_go) begin
      rd_bank_q <= rd_bank;
    end
  end

  assign rd_data = rd_word[rd_bank_q];

endmodule

`default_nettype wire

// ==== verilog/hog_bin_accum.sv ====
// Stage 2 of the accumulator. Adds each lane increment to the word read from
// its bank and presents the port-B write in the same cycle. The last write per
// bank is kept so a back-to-back hit on the same word sums the fresh value.
`timescale 1ns/1ps
`default_nettype none

module hog_bin_accum import hog_pkg::*; (
  input  logic       aclk,
  input  logic       rst_n,
  input  bank_lane_t lane_q  [NUM_BANKS],
  input  hist_t      rd_word [NUM_BANKS],
  output bank_lane_t wr_lane [NUM_BANKS]
);

  logic [NUM_BANKS-1:0] prev_en;                // bank wrote on the last edge
  bank_addr_t           prev_addr [NUM_BANKS];
  hist_t                prev_val  [NUM_BANKS];
  logic [NUM_BANKS-1:0] fwd_hit;
  hist_t                base_val  [NUM_BANKS];

  // ------------------------------------------------------------
  // bypass compare and add
  // ------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      // port A read the old word while the previous write landed
      fwd_hit[k]      = prev_en[k] && (prev_addr[k] == lane_q[k].addr);
      base_val[k]     = fwd_hit[k] ? prev_val[k] : rd_word[k];
      wr_lane[k].en   = lane_q[k].en;
      wr_lane[k].addr = lane_q[k].addr;
      wr_lane[k].inc  = base_val[k] + lane_q[k].inc; // summed count, not the increment
    end
  end

  // ------------------------------------------------------------
  // write history, one deep is enough
  // ------------------------------------------------------------
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      prev_en <= '0;
    end else begin
      for (int k = 0; k < NUM_BANKS; k++) begin
        prev_en[k] <= wr_lane[k].en;
      end
    end
  end

  always_ff @(posedge aclk) begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      prev_addr[k] <= wr_lane[k].addr;
      prev_val[k]  <= wr_lane[k].inc;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hog_cell_addr.sv ====
// Stage 1 of the accumulator. Maps one mod sample onto its four target cells,
// routes each cell to its bank by parity and drives the port-A read addresses.
// The same lanes are registered for the add stage one cycle later.
`timescale 1ns/1ps
`default_nettype none

module hog_cell_addr import hog_pkg::*; (
  input  logic        aclk,
  input  logic        rst_n,
  input  logic        sample_valid,
  input  hog_sample_t sample,
  output bank_lane_t  rd_lane [NUM_BANKS],
  output bank_lane_t  lane_q  [NUM_BANKS]
);

  logic [6:0]           own_row;          // one spare bit so -1 and 34 fall out of range
  logic [6:0]           own_col;
  logic [6:0]           nb_row;
  logic [6:0]           nb_col;
  logic [6:0]           tgt_row [4];
  logic [6:0]           tgt_col [4];
  logic [3:0]           tgt_ok;
  bank_sel_t            tgt_bank [4];
  logic [NUM_BANKS-1:0] en_q;
  bank_addr_t           addr_q [NUM_BANKS];
  hist_t                inc_q  [NUM_BANKS];

  // ------------------------------------------------------------
  // target cells
  // ------------------------------------------------------------
  assign own_row = {1'b0, sample.mod_row[7:2]};
  assign own_col = {1'b0, sample.mod_col[7:2]};
  assign nb_row  = sample.mod_row[1] ? own_row + 7'd1 : own_row - 7'd1; // lower half steps down
  assign nb_col  = sample.mod_col[1] ? own_col + 7'd1 : own_col - 7'd1; // right half steps right

  always_comb begin
    tgt_row[0] = own_row; // own cell, intensity 0
    tgt_col[0] = own_col;
    tgt_row[1] = nb_row;  // vertical, intensity 1
    tgt_col[1] = own_col;
    tgt_row[2] = nb_row;  // diagonal, intensity 2
    tgt_col[2] = nb_col;
    tgt_row[3] = own_row; // horizontal, intensity 3
    tgt_col[3] = nb_col;
  end

  // ------------------------------------------------------------
  // bank routing, the four targets always differ in parity
  // ------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      rd_lane[k] = '0;
    end
    for (int j = 0; j < 4; j++) begin
      tgt_ok[j]   = (tgt_row[j] < 7'(CELLS_PER_SIDE)) && (tgt_col[j] < 7'(CELLS_PER_SIDE));
      tgt_bank[j] = hog_bank_of(tgt_row[j][5:0], tgt_col[j][5:0]);
      rd_lane[tgt_bank[j]].en   = sample_valid & tgt_ok[j]; // off-grid cells just skip
      rd_lane[tgt_bank[j]].addr = hog_bank_addr(tgt_row[j][5:0], tgt_col[j][5:0], sample.bin);
      rd_lane[tgt_bank[j]].inc  = sample.intensity[j];
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      en_q <= '0;
    end else begin
      for (int k = 0; k < NUM_BANKS; k++) begin
        en_q[k] <= rd_lane[k].en;
      end
    end
  end

  always_ff @(posedge aclk) begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      addr_q[k] <= rd_lane[k].addr; // lines up with the port-A read data
      inc_q[k]  <= rd_lane[k].inc;
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      lane_q[k] = '{en: en_q[k], addr: addr_q[k], inc: inc_q[k]};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hog_cell_bank.sv ====
// One histogram bank: true dual-port memory with a registered port-A read.
// Port A reads old data when the same word is written in that cycle.
`timescale 1ns/1ps
`default_nettype none

module hog_cell_bank import hog_pkg::*; (
  input  logic       aclk,
  input  logic       a_we,
  input  bank_addr_t a_addr,
  input  hist_t      a_din,
  output hist_t      a_dout,
  input  logic       b_we,
  input  bank_addr_t b_addr,
  input  hist_t      b_din
);

  hist_t mem [BANK_DEPTH];

  always_ff @(posedge aclk) begin
    if (a_we) begin
      mem[a_addr] <= a_din; // only used by the clear
    end
    if (b_we) begin
      mem[b_addr] <= b_din;
    end
    a_dout <= mem[a_addr];  // read before write
  end

endmodule

`default_nettype wire

// ==== verilog/hog_pkg.sv ====
// Shared types, bank geometry and address helpers for the HOG cell-histogram
// accumulator. Every module takes what it needs by wildcard import.
`default_nettype none

package hog_pkg;

  // ------------------------------------------------------------
  // widths with a meaning
  // ------------------------------------------------------------
  typedef logic [7:0]  mod_coord_t;  // mod row/col, 0..135
  typedef logic [5:0]  cell_coord_t; // cell row/col, 0..33
  typedef logic [4:0]  bin_t;        // orientation bin, 0..17
  typedef logic [34:0] hist_t;       // intensity or bin count
  typedef logic [12:0] bank_addr_t;  // word inside one bank
  typedef logic [1:0]  bank_sel_t;   // bank index

  localparam int unsigned NUM_BANKS       = 4;
  localparam int unsigned NUM_BINS        = 18;
  localparam int unsigned CELLS_PER_SIDE  = 34;
  localparam int unsigned BLOCKS_PER_SIDE = 17;   // 2x2 cell blocks per side
  localparam int unsigned BANK_DEPTH      = 5202; // 17*17 blocks * 18 bins
  localparam mod_coord_t  LAST_MOD        = 8'd135;
  localparam int unsigned CLEAR_WORDS     = 2601; // two words per cycle

  // ------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------
  typedef struct packed {
    mod_coord_t  mod_row;
    mod_coord_t  mod_col;
    bin_t        bin;
    hist_t [3:0] intensity; // own, vertical, diagonal, horizontal
  } hog_sample_t;

  typedef struct packed {
    logic       en;
    bank_addr_t addr;
    hist_t      inc;  // increment, or summed value on the write side
  } bank_lane_t;

  typedef struct packed {
    cell_coord_t cell_row;
    cell_coord_t cell_col;
    bin_t        bin;
  } rd_req_t;

  typedef enum logic {
    ST_CLEAR,
    ST_RUN
  } clear_state_t;

  // bank = 3 - (2*row parity + col parity)
  function automatic bank_sel_t hog_bank_of(cell_coord_t row, cell_coord_t col);
    return bank_sel_t'(NUM_BANKS - 1) - {row[0], col[0]};
  endfunction

  // ((row/2)*17 + col/2)*18 + bin
  function automatic bank_addr_t hog_bank_addr(cell_coord_t row, cell_coord_t col, bin_t bin);
    bank_addr_t blk;
    blk = bank_addr_t'(row[5:1]) * bank_addr_t'(BLOCKS_PER_SIDE) + bank_addr_t'(col[5:1]);
    return blk * bank_addr_t'(NUM_BINS) + bank_addr_t'(bin);
  endfunction

endpackage

`default_nettype wire
